//--- hdl/bk_pkg.sv
// Shared width default, ALU opcode enum, propagate-generate pair
// and the request, flag and response structs
package bk_pkg;

    // Default operand width, taken up by the top level
    localparam int bk_width = 8;

    // ALU opcodes
    // Subtract forms invert b before the adder
    typedef enum logic [1:0] {
        OP_ADD = 2'b00,
        OP_ADC = 2'b01,
        OP_SUB = 2'b10,
        OP_SBB = 2'b11
    } alu_op_e;

    // One request into the operand stage
    // cin is carry for ADC and borrow for SBB
    typedef struct packed {
        alu_op_e               op;
        logic [bk_width-1:0]   a;
        logic [bk_width-1:0]   b;
        logic                  cin;
    } alu_req_t;

    // Group generate and propagate for one prefix-tree node
    typedef struct packed {
        logic g;
        logic p;
    } bk_pg_t;

    // Status flags of one result
    typedef struct packed {
        logic carry;   // Carry out on add, borrow on subtract
        logic zero;    // Result is all zeros
        logic neg;     // Top bit of the result
        logic ovf;     // Signed overflow
    } alu_flags_t;

    // One response out of the result stage
    typedef struct packed {
        logic [bk_width-1:0]   result;
        alu_flags_t            flags;
    } alu_rsp_t;

endpackage

//--- hdl/bk_prefix_tree.sv
// Generic Brent-Kung carry tree over bit propagate and generate
// Up-sweep builds aligned groups, down-sweep completes the rest
`timescale 1ns/100ps

module bk_prefix_tree #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0] p,
    input  logic [WIDTH-1:0] g,
    input  logic             cin,
    output logic [WIDTH-1:0] c,
    output logic             cout
);

    // Number of up-sweep merge levels
    localparam int LEVELS = $clog2(WIDTH);

    // Full prefix ending at each bit, bit 0 upwards
    bk_pkg::bk_pg_t [WIDTH-1:0] pre;

    // Tree shape relies on power-of-two spans
    if ((WIDTH < 8) || ((WIDTH & (WIDTH - 1)) != 0)) begin : g_width_chk
        $error("bk_prefix_tree: WIDTH must be a power of two of at least 8");
    end

    // Merge of an upper group with the adjacent lower group
    function automatic bk_pkg::bk_pg_t pg_merge(
        input bk_pkg::bk_pg_t hi,
        input bk_pkg::bk_pg_t lo
    );
        bk_pkg::bk_pg_t res;
        res.g = hi.g | (hi.p & lo.g);
        res.p = hi.p & lo.p;
        return res;
    endfunction

    // Up-sweep
    // Level l merges pairs at distance 2**(l-1)
    // Bit i is merged when i+1 is a multiple of 2**l
    // Afterwards bit i spans the lowest set bit of i+1
    for (genvar l = 0; l <= LEVELS; l++) begin : g_up
        bk_pkg::bk_pg_t [WIDTH-1:0] node;

        for (genvar i = 0; i < WIDTH; i++) begin : g_bit
            if (l == 0) begin : g_leaf
                // Leaves are the raw bit pairs
                assign node[i] = '{g: g[i], p: p[i]};
            end else if (((i + 1) % (1 << l)) == 0) begin : g_merge
                assign node[i] = pg_merge(g_up[l-1].node[i],
                                          g_up[l-1].node[i - (1 << (l - 1))]);
            end else begin : g_pass
                assign node[i] = g_up[l-1].node[i];
            end
        end
    end

    // Down-sweep
    // Level 0 copies the up-sweep result
    // Level k fills bits whose group is DIST wide, from the prefix just below
    // DIST runs WIDTH/4, WIDTH/8 ... 1
    for (genvar k = 0; k < LEVELS; k++) begin : g_dn
        localparam int DIST = WIDTH >> (k + 1);

        bk_pkg::bk_pg_t [WIDTH-1:0] node;

        for (genvar i = 0; i < WIDTH; i++) begin : g_bit
            if (k == 0) begin : g_seed
                assign node[i] = g_up[LEVELS].node[i];
            end else if ((((i + 1) % (2 * DIST)) == DIST) && (i >= 2 * DIST)) begin : g_fill
                // Bit i-DIST already holds a full prefix at this point
                assign node[i] = pg_merge(g_dn[k-1].node[i], g_dn[k-1].node[i - DIST]);
            end else begin : g_pass
                assign node[i] = g_dn[k-1].node[i];
            end
        end
    end

    assign pre = g_dn[LEVELS-1].node;

    // Carry into bit 0 is the external carry
    assign c[0] = cin;

    // Carry into bit i comes from the prefix over bits 0..i-1 plus cin
    for (genvar i = 1; i < WIDTH; i++) begin : g_carry
        assign c[i] = pre[i-1].g | (pre[i-1].p & cin);
    end

    // Carry out from the full-width group
    assign cout = pre[WIDTH-1].g | (pre[WIDTH-1].p & cin);

endmodule

//--- hdl/bk_adder.sv
// Combinational Brent-Kung adder
// Bit propagate/generate, prefix carries and sum bits
`timescale 1ns/100ps

module bk_adder #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic             cin,
    output logic [WIDTH-1:0] sum,
    output logic             cout
);

    // Bit propagate and generate
    logic [WIDTH-1:0] p;
    logic [WIDTH-1:0] g;

    // Carry into each bit position
    logic [WIDTH-1:0] c;

    // Half-adder terms per bit
    assign p = a ^ b;
    assign g = a & b;

    // All carries in log depth
    bk_prefix_tree #(
        .WIDTH (WIDTH)
    ) u_tree (
        .p    (p),
        .g    (g),
        .cin  (cin),
        .c    (c),
        .cout (cout)
    );

    // Sum bit is propagate xor incoming carry
    assign sum = p ^ c;

endmodule

//--- hdl/alu_operand_stage.sv
// ALU operand stage
// Request register plus operand and carry-in conditioning for the adder
`timescale 1ns/100ps

module alu_operand_stage #(
    parameter int WIDTH = bk_pkg::bk_width
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  bk_pkg::alu_req_t req,
    output logic [WIDTH-1:0] op_a,
    output logic [WIDTH-1:0] op_b,
    output logic             carry_in,
    output logic             stage_valid,
    output bk_pkg::alu_op_e  stage_op
);

    // Held request, loaded on each strobe
    bk_pkg::alu_req_t req_q;

    // Valid bit of the held request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= in_valid;
        end
    end

    // Payload only loads with a strobe
    always_ff @(posedge clk) begin
        if (in_valid) begin
            req_q <= req;
        end
    end

    assign stage_op = req_q.op;
    assign op_a     = req_q.a;

    // Subtract is a + ~b + 1
    // SBB drops the +1 when a borrow comes in
    always_comb begin
        op_b     = req_q.b;
        carry_in = 1'b0;
        case (req_q.op)
            bk_pkg::OP_ADD: begin
                carry_in = 1'b0;
            end
            bk_pkg::OP_ADC: begin
                carry_in = req_q.cin;
            end
            bk_pkg::OP_SUB: begin
                op_b     = ~req_q.b;
                carry_in = 1'b1;
            end
            bk_pkg::OP_SBB: begin
                op_b     = ~req_q.b;
                carry_in = ~req_q.cin;
            end
            default: begin
                op_b     = req_q.b;
                carry_in = 1'b0;
            end
        endcase
    end

    // An accepted request must carry a known opcode
    a_req_op_known: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> !$isunknown(req.op));

endmodule

//--- hdl/alu_result_stage.sv
// ALU result stage
// Flag derivation from the adder outputs and the response register
`timescale 1ns/100ps

module alu_result_stage #(
    parameter int WIDTH = bk_pkg::bk_width
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             stage_valid,
    input  bk_pkg::alu_op_e  stage_op,
    input  logic             op_a_msb,
    input  logic             op_b_msb,
    input  logic [WIDTH-1:0] sum,
    input  logic             cout,
    output logic             out_valid,
    output bk_pkg::alu_rsp_t rsp
);

    // Flags of the current adder result
    bk_pkg::alu_flags_t flags_d;

    // Subtract forms report borrow, not carry
    logic is_sub;

    assign is_sub = (stage_op == bk_pkg::OP_SUB) || (stage_op == bk_pkg::OP_SBB);

    always_comb begin
        // Borrow is the inverse of the adder carry out
        flags_d.carry = is_sub ? ~cout : cout;
        flags_d.zero  = (sum == '0);
        flags_d.neg   = sum[WIDTH-1];
        // Sign bits seen by the adder, so b is already inverted on subtract
        flags_d.ovf   = (op_a_msb == op_b_msb) && (sum[WIDTH-1] != op_a_msb);
    end

    // Response register
    // Held between pulses, overwritten by the next result
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            rsp       <= '0;
        end else begin
            out_valid <= stage_valid;
            if (stage_valid) begin
                rsp.result <= sum;
                rsp.flags  <= flags_d;
            end
        end
    end

    // Each valid stage gives one pulse in the next cycle
    a_out_follows: assert property (@(posedge clk) disable iff (!rst_n)
        stage_valid |=> out_valid);

    // No pulse without a valid stage the cycle before
    a_no_spurious: assert property (@(posedge clk) disable iff (!rst_n)
        !stage_valid |=> !out_valid);

    // Zero flag agrees with the registered result
    a_zero_flag: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && rsp.flags.zero) |-> (rsp.result == '0));

endmodule

//--- hdl/bk_alu_top.sv
// Two-stage ALU top level
// Operand stage, Brent-Kung adder and result stage
`timescale 1ns/100ps

module bk_alu_top #(
    parameter int WIDTH = bk_pkg::bk_width
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  bk_pkg::alu_req_t req,
    output logic             out_valid,
    output bk_pkg::alu_rsp_t rsp
);

    // Request and response structs are sized by the package width
    if (WIDTH != bk_pkg::bk_width) begin : g_width_chk
        $error("bk_alu_top: WIDTH must equal bk_pkg::bk_width");
    end

    // Conditioned operands into the adder
    logic [WIDTH-1:0] op_a;
    logic [WIDTH-1:0] op_b;
    logic             carry_in;

    // Operand stage status towards the result stage
    logic             stage_valid;
    bk_pkg::alu_op_e  stage_op;

    // Adder outputs
    logic [WIDTH-1:0] sum;
    logic             cout;

    alu_operand_stage #(
        .WIDTH (WIDTH)
    ) u_operand (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .req         (req),
        .op_a        (op_a),
        .op_b        (op_b),
        .carry_in    (carry_in),
        .stage_valid (stage_valid),
        .stage_op    (stage_op)
    );

    bk_adder #(
        .WIDTH (WIDTH)
    ) u_adder (
        .a    (op_a),
        .b    (op_b),
        .cin  (carry_in),
        .sum  (sum),
        .cout (cout)
    );

    // Sign bits go over after b conditioning
    alu_result_stage #(
        .WIDTH (WIDTH)
    ) u_result (
        .clk         (clk),
        .rst_n       (rst_n),
        .stage_valid (stage_valid),
        .stage_op    (stage_op),
        .op_a_msb    (op_a[WIDTH-1]),
        .op_b_msb    (op_b[WIDTH-1]),
        .sum         (sum),
        .cout        (cout),
        .out_valid   (out_valid),
        .rsp         (rsp)
    );

endmodule

//--- tests/bk_alu_tb.sv
// Testbench for the two-stage Brent-Kung ALU
// Stimulus table, reference model, in-order response checks and timeout
`timescale 1ns/100ps

module bk_alu_tb;

    localparam int WIDTH = bk_pkg::bk_width;

    // Operand patterns scaled to the width
    localparam logic [WIDTH-1:0] all_ones = '1;
    localparam logic [WIDTH-1:0] zero     = '0;
    localparam logic [WIDTH-1:0] one      = {{(WIDTH-1){1'b0}}, 1'b1};
    localparam logic [WIDTH-1:0] msb_only = {1'b1, {(WIDTH-1){1'b0}}};
    localparam logic [WIDTH-1:0] max_pos  = {1'b0, {(WIDTH-1){1'b1}}};
    localparam logic [WIDTH-1:0] alt_10   = {(WIDTH/2){2'b10}};
    localparam logic [WIDTH-1:0] alt_01   = {(WIDTH/2){2'b01}};
    localparam logic [WIDTH-1:0] low_half = {{(WIDTH/2){1'b0}}, {(WIDTH/2){1'b1}}};

    localparam int reset_cycles = 5;
    localparam int random_count = 200;

    logic             clk;
    logic             rst_n;
    logic             in_valid;
    bk_pkg::alu_req_t req;
    logic             out_valid;
    bk_pkg::alu_rsp_t rsp;

    // Stimulus table with the expected response of each entry
    bk_pkg::alu_req_t req_tab[$];
    bk_pkg::alu_rsp_t exp_tab[$];

    // Requests in flight and the cycle each pulse is due
    int idx_q[$];
    int due_q[$];

    int cycle_cnt;
    int timeout_limit;
    int pass_cnt;
    int fail_cnt;
    int err_cnt;
    bit entry_ok;

    bk_alu_top #(
        .WIDTH (WIDTH)
    ) UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .req       (req),
        .out_valid (out_valid),
        .rsp       (rsp)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Cycles since reset release
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_cnt <= 0;
        end else begin
            cycle_cnt <= cycle_cnt + 1;
        end
    end

    // Run limit from the table length
    always @(posedge clk) begin
        if ((timeout_limit > 0) && (cycle_cnt >= timeout_limit)) begin
            $display("Timeout: run still busy after %0d cycles", timeout_limit);
            $display("Test failures found");
            $finish;
        end
    end

    // Expected response from plain WIDTH+1-bit arithmetic
    function automatic bk_pkg::alu_rsp_t model_rsp(input bk_pkg::alu_req_t r);
        logic [WIDTH:0]        ua;
        logic [WIDTH:0]        ub;
        logic [WIDTH:0]        uc;
        logic [WIDTH:0]        ures;
        logic signed [WIDTH:0] sa;
        logic signed [WIDTH:0] sb;
        logic signed [WIDTH:0] sres;
        bk_pkg::alu_rsp_t      res;
        ua = {1'b0, r.a};
        ub = {1'b0, r.b};
        uc = '0;
        // Carry or borrow only for the extended forms
        if ((r.op == bk_pkg::OP_ADC) || (r.op == bk_pkg::OP_SBB)) begin
            uc[0] = r.cin;
        end
        sa = {r.a[WIDTH-1], r.a};
        sb = {r.b[WIDTH-1], r.b};
        if ((r.op == bk_pkg::OP_SUB) || (r.op == bk_pkg::OP_SBB)) begin
            // Top bit of the unsigned difference is the borrow
            ures = ua - ub - uc;
            sres = sa - sb - $signed(uc);
        end else begin
            ures = ua + ub + uc;
            sres = sa + sb + $signed(uc);
        end
        res.result      = ures[WIDTH-1:0];
        res.flags.carry = ures[WIDTH];
        res.flags.zero  = (ures[WIDTH-1:0] == '0);
        res.flags.neg   = ures[WIDTH-1];
        // Signed result outside the WIDTH-bit range
        res.flags.ovf   = (sres[WIDTH] != sres[WIDTH-1]);
        return res;
    endfunction

    function automatic string op_name(input bk_pkg::alu_op_e op);
        case (op)
            bk_pkg::OP_ADD: return "ADD";
            bk_pkg::OP_ADC: return "ADC";
            bk_pkg::OP_SUB: return "SUB";
            bk_pkg::OP_SBB: return "SBB";
            default:        return "???";
        endcase
    endfunction

    task automatic add_vec(input bk_pkg::alu_op_e op, input logic [WIDTH-1:0] a,
                           input logic [WIDTH-1:0] b, input logic cin);
        bk_pkg::alu_req_t r;
        r.op  = op;
        r.a   = a;
        r.b   = b;
        r.cin = cin;
        req_tab.push_back(r);
        exp_tab.push_back(model_rsp(r));
    endtask

    task automatic build_table();
        bk_pkg::alu_op_e op;
        // Plain add and every carry path of the tree
        add_vec(bk_pkg::OP_ADD, zero, zero, 1'b0);
        add_vec(bk_pkg::OP_ADD, all_ones, one, 1'b0);
        add_vec(bk_pkg::OP_ADD, all_ones, all_ones, 1'b0);
        add_vec(bk_pkg::OP_ADD, alt_10, alt_01, 1'b0);
        add_vec(bk_pkg::OP_ADD, alt_01, alt_01, 1'b0);
        add_vec(bk_pkg::OP_ADD, alt_10, alt_10, 1'b0);
        add_vec(bk_pkg::OP_ADD, low_half, one, 1'b0);
        add_vec(bk_pkg::OP_ADD, zero, zero, 1'b1);
        // Carry in used by ADC only
        add_vec(bk_pkg::OP_ADC, all_ones, zero, 1'b1);
        add_vec(bk_pkg::OP_ADC, alt_10, alt_01, 1'b1);
        add_vec(bk_pkg::OP_ADC, low_half, zero, 1'b0);
        add_vec(bk_pkg::OP_ADC, max_pos, zero, 1'b1);
        // Borrow reporting and zero on equal operands
        add_vec(bk_pkg::OP_SUB, zero, zero, 1'b0);
        add_vec(bk_pkg::OP_SUB, alt_01, alt_01, 1'b0);
        add_vec(bk_pkg::OP_SUB, zero, one, 1'b0);
        add_vec(bk_pkg::OP_SUB, all_ones, one, 1'b0);
        add_vec(bk_pkg::OP_SUB, zero, zero, 1'b1);
        add_vec(bk_pkg::OP_SBB, zero, zero, 1'b1);
        add_vec(bk_pkg::OP_SBB, one, zero, 1'b1);
        add_vec(bk_pkg::OP_SBB, alt_10, alt_01, 1'b0);
        add_vec(bk_pkg::OP_SBB, alt_01, alt_10, 1'b1);
        // Sign boundary
        add_vec(bk_pkg::OP_ADD, max_pos, one, 1'b0);
        add_vec(bk_pkg::OP_ADD, msb_only, msb_only, 1'b0);
        add_vec(bk_pkg::OP_ADD, msb_only, all_ones, 1'b0);
        add_vec(bk_pkg::OP_SUB, msb_only, one, 1'b0);
        add_vec(bk_pkg::OP_SUB, max_pos, all_ones, 1'b0);
        add_vec(bk_pkg::OP_SBB, msb_only, zero, 1'b1);
        add_vec(bk_pkg::OP_ADC, max_pos, max_pos, 1'b1);
        // Random fill from the seed set at the start of the run
        for (int i = 0; i < random_count; i++) begin
            op = bk_pkg::alu_op_e'(2'($urandom_range(3, 0)));
            add_vec(op, WIDTH'($urandom), WIDTH'($urandom), 1'($urandom_range(1, 0)));
        end
    endtask

    task automatic check_result(input int idx, input logic [WIDTH-1:0] got,
                                input logic [WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("error rsp.result entry %0d: got 0x%h, expected 0x%h", idx, got, exp);
            entry_ok = 1'b0;
        end
    endtask

    task automatic check_flags(input int idx, input bk_pkg::alu_flags_t got,
                               input bk_pkg::alu_flags_t exp);
        if (got !== exp) begin
            $display("error rsp.flags entry %0d: got 0x%h, expected 0x%h (carry zero neg ovf)",
                     idx, got, exp);
            entry_ok = 1'b0;
        end
    endtask

    // Out of reset the response side is idle and cleared
    task automatic check_reset();
        bit ok;
        ok = 1'b1;
        if (out_valid !== 1'b0) begin
            $display("error out_valid in reset: got 0x%h, expected 0x0", out_valid);
            ok = 1'b0;
        end
        if (rsp !== '0) begin
            $display("error rsp in reset: got 0x%h, expected 0x0", rsp);
            ok = 1'b0;
        end
        if (ok) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
        $display("test reset: %s", ok ? "ok" : "FAIL");
    endtask

    task automatic report_entry(input int idx);
        if (entry_ok) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
        $display("test %0d %s a=0x%h b=0x%h cin=%b: %s", idx, op_name(req_tab[idx].op),
                 req_tab[idx].a, req_tab[idx].b, req_tab[idx].cin, entry_ok ? "ok" : "FAIL");
    endtask

    // Monitor samples at mid-cycle and pops one expectation per pulse
    always @(negedge clk) begin : monitor
        int idx;
        int due;
        if (rst_n === 1'b1) begin
            if (out_valid === 1'b1) begin
                if (idx_q.size() == 0) begin
                    $display("out_valid pulsed at cycle %0d with no request in flight",
                             cycle_cnt);
                    err_cnt++;
                end else begin
                    idx      = idx_q.pop_front();
                    due      = due_q.pop_front();
                    entry_ok = 1'b1;
                    // Fixed two-cycle latency from the strobe
                    if (cycle_cnt != due) begin
                        $display("Response to entry %0d came at cycle %0d, not cycle %0d",
                                 idx, cycle_cnt, due);
                        entry_ok = 1'b0;
                    end
                    check_result(idx, rsp.result, exp_tab[idx].result);
                    check_flags(idx, rsp.flags, exp_tab[idx].flags);
                    report_entry(idx);
                end
            end else if (out_valid !== 1'b0) begin
                $display("out_valid is unknown at cycle %0d", cycle_cnt);
                err_cnt++;
            end
        end
    end

    initial begin
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        req           = '0;
        pass_cnt      = 0;
        fail_cnt      = 0;
        err_cnt       = 0;
        timeout_limit = 0;
        void'($urandom(76732));
        build_table();
        timeout_limit = req_tab.size() + 20;

        repeat (reset_cycles) @(posedge clk);
        #1;
        check_reset();
        rst_n = 1'b1;

        // One request per cycle with no gaps
        for (int i = 0; i < req_tab.size(); i++) begin
            @(posedge clk);
            #1;
            in_valid = 1'b1;
            req      = req_tab[i];
            idx_q.push_back(i);
            due_q.push_back(cycle_cnt + 2);
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        req      = '0;

        // Drain the pipeline and then watch for stray pulses
        for (int w = 0; (w < 4) && (idx_q.size() != 0); w++) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        if (idx_q.size() != 0) begin
            $display("%0d requests never produced a response", idx_q.size());
            err_cnt += idx_q.size();
        end

        $display("%0d tests: %0d passed, %0d failed, %0d other errors",
                 pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
        if ((fail_cnt == 0) && (err_cnt == 0)) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- tb.f
hdl/bk_pkg.sv
hdl/bk_prefix_tree.sv
hdl/bk_adder.sv
hdl/alu_operand_stage.sv
hdl/alu_result_stage.sv
hdl/bk_alu_top.sv
tests/bk_alu_tb.sv

//--- Makefile
# Verilator build and run of the Brent-Kung ALU testbench

TOP = bk_alu_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

# Build the simulation executable from the file list
compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f tb.f -Mdir obj_dir -o $(TOP)_sim

# Run and decide pass or fail from the log
run: compile
	./obj_dir/$(TOP)_sim | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
